// ==== proc_pkg.sv ====
/*
 * Processor core package
 * Word and register index widths, instruction opcodes, branch
 * conditions, sequencer states and write-back source select
 */
package proc_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int DATA_W = 16;  // Data, address and instruction word
  localparam int REG_AW = 4;   // Register index

  //////////////////////////////
  // Instruction opcodes
  //////////////////////////////
  typedef enum logic [3:0] {
    OP_ADD = 4'b0000,  // Saturating add
    OP_SUB = 4'b0001,  // Saturating subtract
    OP_XOR = 4'b0010,
    OP_SLL = 4'b0100,  // Shifts and rotate take imm4
    OP_SRA = 4'b0101,
    OP_ROR = 4'b0110,
    OP_LW  = 4'b1000,
    OP_SW  = 4'b1001,
    OP_LLB = 4'b1010,  // Byte loads take imm8
    OP_LHB = 4'b1011,
    OP_B   = 4'b1100,
    OP_PCS = 4'b1110,
    OP_HLT = 4'b1111
  } opcode_t;

  // Branch condition codes in bits 11 to 9 of B
  typedef enum logic [2:0] {
    CC_NE, CC_EQ, CC_GT, CC_LT, CC_GE, CC_LE, CC_OV, CC_UN
  } cond_t;

  // Instruction sequencer states
  typedef enum logic [2:0] {
    ST_FETCH, ST_WAIT_INST, ST_EXEC, ST_WAIT_LOAD, ST_HALT
  } seq_state_t;

  // Register write source
  typedef enum logic [1:0] {
    WB_ALU,   // ALU result
    WB_MEM,   // Load data
    WB_PC     // PC+2 for PCS
  } wb_sel_t;

endpackage

// ==== fetch_unit.sv ====
/*
 * Fetch unit
 * Holds the program counter and the instruction register. Checks the
 * branch condition against the flags and picks the next PC
 */
`timescale 1ns/100ps
module fetch_unit #(
  parameter logic [15:0] RESET_PC = 16'h0000
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        inst_valid,   // Fetch read returned
  input  logic                        pc_advance,   // Instruction done
  input  logic [proc_pkg::DATA_W-1:0] mem_data_in,
  input  logic                        flag_z,
  input  logic                        flag_n,
  input  logic                        flag_v,
  output logic [proc_pkg::DATA_W-1:0] pc,
  output logic [proc_pkg::DATA_W-1:0] inst,
  output logic [proc_pkg::DATA_W-1:0] pc_plus2
);

  logic                        is_branch;
  logic                        cond_met;
  logic [proc_pkg::DATA_W-1:0] br_target;

  assign pc_plus2  = pc + 16'd2;
  assign is_branch = (inst[15:12] == proc_pkg::OP_B);
  assign br_target = pc_plus2 + {{6{inst[8]}}, inst[8:0], 1'b0};  // Word offset

  // Condition codes against Z N V
  always_comb begin
    case (proc_pkg::cond_t'(inst[11:9]))
      proc_pkg::CC_NE: cond_met = ~flag_z;
      proc_pkg::CC_EQ: cond_met = flag_z;
      proc_pkg::CC_GT: cond_met = ~flag_z & ~flag_n;
      proc_pkg::CC_LT: cond_met = flag_n;
      proc_pkg::CC_GE: cond_met = flag_z | ~flag_n;
      proc_pkg::CC_LE: cond_met = flag_z | flag_n;
      proc_pkg::CC_OV: cond_met = flag_v;
      default:         cond_met = 1'b1;  // Unconditional
    endcase
  end

  //////////////////////////////
  // Program counter
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (pc_advance) begin
      pc <= (is_branch && cond_met) ? br_target : pc_plus2;
    end
  end

  // Instruction register loads on the fetch return
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      inst <= mem_data_in;
    end
  end

endmodule

// ==== reg_file.sv ====
/*
 * Register file
 * Sixteen 16-bit registers with r0 read as zero, operand port
 * selection and the write-back source mux
 */
`timescale 1ns/100ps
module reg_file (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [proc_pkg::DATA_W-1:0] inst,
  input  logic                        reg_we,
  input  proc_pkg::wb_sel_t           wb_sel,
  input  logic [proc_pkg::DATA_W-1:0] alu_result,
  input  logic [proc_pkg::DATA_W-1:0] mem_data_in,
  input  logic [proc_pkg::DATA_W-1:0] pc_plus2,
  output logic [proc_pkg::DATA_W-1:0] op_a,
  output logic [proc_pkg::DATA_W-1:0] op_b
);

  logic [proc_pkg::DATA_W-1:0] regs [16];
  logic [proc_pkg::REG_AW-1:0] rd, ra, rb;
  logic [proc_pkg::DATA_W-1:0] wr_data;
  logic                        byte_ld;

  assign rd      = inst[11:8];
  assign byte_ld = (inst[15:12] == proc_pkg::OP_LLB) || (inst[15:12] == proc_pkg::OP_LHB);
  assign ra      = byte_ld ? rd : inst[7:4];                             // rd keeps other byte
  assign rb      = (inst[15:12] == proc_pkg::OP_SW) ? rd : inst[3:0];    // SW data register

  assign op_a = (ra == '0) ? '0 : regs[ra];  // r0 reads zero
  assign op_b = (rb == '0) ? '0 : regs[rb];

  // Write-back source
  always_comb begin
    case (wb_sel)
      proc_pkg::WB_MEM: wr_data = mem_data_in;
      proc_pkg::WB_PC:  wr_data = pc_plus2;
      default:          wr_data = alu_result;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we && (rd != '0)) begin
      regs[rd] <= wr_data;
    end
  end

endmodule

// ==== alu.sv ====
/*
 * ALU
 * Saturating add and subtract, XOR, shifts and rotate, byte loads
 * and load/store address. Holds the Z N V flag register
 */
`timescale 1ns/100ps
module alu (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [proc_pkg::DATA_W-1:0] inst,
  input  logic [proc_pkg::DATA_W-1:0] op_a,
  input  logic [proc_pkg::DATA_W-1:0] op_b,
  input  logic                        flag_en,   // Flag-setting op in EXEC
  output logic [proc_pkg::DATA_W-1:0] alu_result,
  output logic                        flag_z,
  output logic                        flag_n,
  output logic                        flag_v
);

  proc_pkg::opcode_t           opcode;
  logic [3:0]                  imm4;
  logic [7:0]                  imm8;
  logic [proc_pkg::DATA_W-1:0] sum, diff, mem_off;
  logic [2*proc_pkg::DATA_W-1:0] rot;
  logic                        add_ovf, sub_ovf, ovf;

  assign opcode = proc_pkg::opcode_t'(inst[15:12]);
  assign imm4   = inst[3:0];
  assign imm8   = inst[7:0];

  //////////////////////////////
  // Arithmetic
  //////////////////////////////
  assign sum     = op_a + op_b;
  assign diff    = op_a - op_b;
  assign add_ovf = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);   // Same signs flip
  assign sub_ovf = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);
  assign rot     = {op_a, op_a} >> imm4;                              // Low half is rotated
  assign mem_off = {{11{imm4[3]}}, imm4, 1'b0};                       // Word offset in bytes

  always_comb begin
    ovf = 1'b0;
    case (opcode)
      proc_pkg::OP_ADD: begin
        ovf        = add_ovf;
        alu_result = add_ovf ? (op_a[15] ? 16'h8000 : 16'h7FFF) : sum;  // Clamp to limit
      end
      proc_pkg::OP_SUB: begin
        ovf        = sub_ovf;
        alu_result = sub_ovf ? (op_a[15] ? 16'h8000 : 16'h7FFF) : diff;
      end
      proc_pkg::OP_XOR: alu_result = op_a ^ op_b;
      proc_pkg::OP_SLL: alu_result = op_a << imm4;
      proc_pkg::OP_SRA: alu_result = $signed(op_a) >>> imm4;
      proc_pkg::OP_ROR: alu_result = rot[proc_pkg::DATA_W-1:0];
      proc_pkg::OP_LLB: alu_result = {op_a[15:8], imm8};    // op_a is rd here
      proc_pkg::OP_LHB: alu_result = {imm8, op_a[7:0]};
      proc_pkg::OP_LW,
      proc_pkg::OP_SW:  alu_result = {op_a[15:1], 1'b0} + mem_off;
      default:          alu_result = '0;
    endcase
  end

  //////////////////////////////
  // Flag register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_z <= 1'b0;
      flag_n <= 1'b0;
      flag_v <= 1'b0;
    end else if (flag_en) begin
      flag_z <= (alu_result == '0);
      // N and V only from add and subtract
      if ((opcode == proc_pkg::OP_ADD) || (opcode == proc_pkg::OP_SUB)) begin
        flag_n <= alu_result[15];
        flag_v <= ovf;
      end
    end
  end

endmodule

// ==== core_seq.sv ====
/*
 * Instruction sequencer
 * Multicycle FSM that fetches, executes and waits on loads. Issues
 * memory requests, register write strobes and the PC advance
 */
`timescale 1ns/100ps
module core_seq (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [proc_pkg::DATA_W-1:0] inst,
  input  logic                        inst_valid,
  input  logic                        load_valid,
  output logic                        fetch_req,
  output logic                        load_req,
  output logic                        store_req,
  output logic                        pc_advance,
  output logic                        reg_we,
  output logic                        flag_en,
  output proc_pkg::wb_sel_t           wb_sel,
  output logic                        hlt
);

  proc_pkg::seq_state_t state, state_nxt;
  proc_pkg::opcode_t    opcode;

  assign opcode = proc_pkg::opcode_t'(inst[15:12]);
  assign hlt    = (state == proc_pkg::ST_HALT);  // Held until reset

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= proc_pkg::ST_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////
  // Next state and strobes
  //////////////////////////////
  always_comb begin
    state_nxt  = state;
    fetch_req  = 1'b0;
    load_req   = 1'b0;
    store_req  = 1'b0;
    pc_advance = 1'b0;
    reg_we     = 1'b0;
    flag_en    = 1'b0;
    wb_sel     = proc_pkg::WB_ALU;
    case (state)
      proc_pkg::ST_FETCH: begin
        fetch_req = 1'b1;
        state_nxt = proc_pkg::ST_WAIT_INST;
      end
      proc_pkg::ST_WAIT_INST: begin
        if (inst_valid) state_nxt = proc_pkg::ST_EXEC;  // Instruction register loads
      end
      proc_pkg::ST_EXEC: begin
        pc_advance = 1'b1;                                // Most ops finish here
        state_nxt  = proc_pkg::ST_FETCH;
        case (opcode)
          proc_pkg::OP_ADD, proc_pkg::OP_SUB, proc_pkg::OP_XOR,
          proc_pkg::OP_SLL, proc_pkg::OP_SRA, proc_pkg::OP_ROR: begin
            reg_we  = 1'b1;
            flag_en = 1'b1;
          end
          proc_pkg::OP_LLB, proc_pkg::OP_LHB: reg_we = 1'b1;
          proc_pkg::OP_PCS: begin
            reg_we = 1'b1;
            wb_sel = proc_pkg::WB_PC;
          end
          proc_pkg::OP_SW: store_req = 1'b1;
          proc_pkg::OP_LW: begin
            load_req   = 1'b1;
            pc_advance = 1'b0;                            // Advance after data returns
            state_nxt  = proc_pkg::ST_WAIT_LOAD;
          end
          proc_pkg::OP_HLT: begin
            pc_advance = 1'b0;                            // pc stays on HLT
            state_nxt  = proc_pkg::ST_HALT;
          end
          default: ;                                      // B and unused opcodes
        endcase
      end
      proc_pkg::ST_WAIT_LOAD: begin
        if (load_valid) begin
          reg_we     = 1'b1;
          wb_sel     = proc_pkg::WB_MEM;
          pc_advance = 1'b1;
          state_nxt  = proc_pkg::ST_FETCH;
        end
      end
      default: state_nxt = proc_pkg::ST_HALT;             // Stuck until reset
    endcase
  end

endmodule

// ==== mem_port.sv ====
/*
 * Memory port
 * Turns request pulses into the registered memory strobe and address.
 * Tags the outstanding read and routes its return to fetch or load
 */
`timescale 1ns/100ps
module mem_port (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        fetch_req,
  input  logic                        load_req,
  input  logic                        store_req,
  input  logic [proc_pkg::DATA_W-1:0] pc,
  input  logic [proc_pkg::DATA_W-1:0] alu_result,   // Load or store address
  input  logic [proc_pkg::DATA_W-1:0] op_b,         // Store data
  input  logic                        mem_data_valid,
  output logic                        mem_en,
  output logic                        mem_wr,
  output logic [proc_pkg::DATA_W-1:0] mem_addr,
  output logic [proc_pkg::DATA_W-1:0] mem_data_out,
  output logic                        inst_valid,
  output logic                        load_valid
);

  logic rd_pending;   // Read outstanding
  logic rd_is_load;   // Outstanding read is a load

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_en     <= 1'b0;
      mem_wr     <= 1'b0;
      rd_pending <= 1'b0;
      rd_is_load <= 1'b0;
    end else begin
      mem_en <= fetch_req | load_req | store_req;  // One-cycle strobe
      mem_wr <= store_req;
      if (fetch_req || load_req) begin
        rd_pending <= 1'b1;
        rd_is_load <= load_req;
      end else if (mem_data_valid) begin
        rd_pending <= 1'b0;
      end
    end
  end

  // Address held until the next request
  always_ff @(posedge clk) begin
    if (fetch_req) begin
      mem_addr <= pc;
    end else if (load_req || store_req) begin
      mem_addr <= alu_result;
    end
    if (store_req) begin
      mem_data_out <= op_b;
    end
  end

  assign inst_valid = mem_data_valid & rd_pending & ~rd_is_load;
  assign load_valid = mem_data_valid & rd_pending & rd_is_load;

endmodule

// ==== proc_top.sv ====
/*
 * Processor top level
 * Multicycle 16-bit core on one shared external memory port
 */
`timescale 1ns/100ps
module proc_top #(
  parameter logic [15:0] RESET_PC = 16'h0000
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        mem_data_valid,
  input  logic [proc_pkg::DATA_W-1:0] mem_data_in,
  output logic                        mem_en,
  output logic                        mem_wr,
  output logic [proc_pkg::DATA_W-1:0] mem_addr,
  output logic [proc_pkg::DATA_W-1:0] mem_data_out,
  output logic                        hlt,
  output logic [proc_pkg::DATA_W-1:0] pc
);

  logic [proc_pkg::DATA_W-1:0] inst, pc_plus2, op_a, op_b, alu_result;
  logic                        fetch_req, load_req, store_req;
  logic                        inst_valid, load_valid, pc_advance;
  logic                        reg_we, flag_en;
  logic                        flag_z, flag_n, flag_v;
  proc_pkg::wb_sel_t           wb_sel;

  //////////////////////////////
  // Core
  //////////////////////////////
  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .pc_advance(pc_advance),
    .mem_data_in(mem_data_in), .flag_z(flag_z), .flag_n(flag_n), .flag_v(flag_v),
    .pc(pc), .inst(inst), .pc_plus2(pc_plus2)
  );

  core_seq u_seq (
    .clk(clk), .rst_n(rst_n), .inst(inst), .inst_valid(inst_valid),
    .load_valid(load_valid), .fetch_req(fetch_req), .load_req(load_req),
    .store_req(store_req), .pc_advance(pc_advance), .reg_we(reg_we),
    .flag_en(flag_en), .wb_sel(wb_sel), .hlt(hlt)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n), .inst(inst), .reg_we(reg_we), .wb_sel(wb_sel),
    .alu_result(alu_result), .mem_data_in(mem_data_in), .pc_plus2(pc_plus2),
    .op_a(op_a), .op_b(op_b)
  );

  alu u_alu (
    .clk(clk), .rst_n(rst_n), .inst(inst), .op_a(op_a), .op_b(op_b),
    .flag_en(flag_en), .alu_result(alu_result),
    .flag_z(flag_z), .flag_n(flag_n), .flag_v(flag_v)
  );

  // External memory bus
  mem_port u_mem (
    .clk(clk), .rst_n(rst_n), .fetch_req(fetch_req), .load_req(load_req),
    .store_req(store_req), .pc(pc), .alu_result(alu_result), .op_b(op_b),
    .mem_data_valid(mem_data_valid), .mem_en(mem_en), .mem_wr(mem_wr),
    .mem_addr(mem_addr), .mem_data_out(mem_data_out),
    .inst_valid(inst_valid), .load_valid(load_valid)
  );

endmodule

// ==== tb_proc.sv ====
/*
 * Processor testbench
 * Builds a random program and runs it on an ISA model to get the expected
 * bus traffic. Then runs the core against a random-latency memory and
 * checks every request, the halt PC and the quiet bus after halt
 */
`timescale 1ns/100ps
module tb_proc;

  localparam int N_RAND     = 60;           // Random instructions
  localparam int DUMP_START = 2 + N_RAND;   // Word index of the first dump store
  localparam int EV_FETCH   = 0;
  localparam int EV_LOAD    = 1;
  localparam int EV_STORE   = 2;
  localparam bit SIDE_REF   = 1'b0;         // Model memory
  localparam bit SIDE_DUT   = 1'b1;         // Memory seen by the core

  logic        clk, rst_n;
  logic        mem_data_valid;
  logic [15:0] mem_data_in;
  logic        mem_en, mem_wr, hlt;
  logic [15:0] mem_addr, mem_data_out, pc;

  logic [15:0] lfsr;
  logic [15:0] mem     [2][32768];          // Word arrays, byte address bits 15 to 1
  bit          written [2][32768];
  logic [15:0] prog [$];
  int          ev_kind [$];                 // Expected bus requests in order
  logic [15:0] ev_addr [$];
  logic [15:0] ev_data [$];
  logic [15:0] hlt_pc;
  int          n_inst;
  int          wd_cycles = 0;
  proc_pkg::seq_state_t seq_state;

  assign seq_state = DUT.u_seq.state;

  proc_top #(.RESET_PC(16'h0000)) DUT (
    .clk(clk), .rst_n(rst_n), .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in),
    .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_data_out(mem_data_out),
    .hlt(hlt), .pc(pc)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  //////////////////////////////
  // Random numbers and memory
  //////////////////////////////
  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);        // One step per bit
      val  = {val[14:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic logic [15:0] mem_read(input bit side, input logic [15:0] addr);
    return written[side][addr[15:1]] ? mem[side][addr[15:1]] : (addr ^ 16'hA5A5);
  endfunction

  task automatic mem_write(input bit side, input logic [15:0] addr, input logic [15:0] data);
    mem[side][addr[15:1]]     = data;
    written[side][addr[15:1]] = 1'b1;
  endtask

  task automatic check_val(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  //////////////////////////////
  // Program generator
  //////////////////////////////
  function automatic logic [15:0] random_inst(input int idx);
    logic [15:0] t, w;
    logic [3:0]  op, rd, rs, rt;
    int          limit;
    t  = take_bits(4);
    op = t[3:0];
    t  = take_bits(4);
    rd = (t[3:0] == 4'd0) ? 4'd1 : ((t[3:0] == 4'd15) ? 4'd14 : t[3:0]);  // r1 to r14
    t  = take_bits(4);
    rs = t[3:0];
    t  = take_bits(4);
    rt = t[3:0];
    if (op == proc_pkg::OP_HLT) op = proc_pkg::OP_SUB;
    case (op)
      proc_pkg::OP_LW, proc_pkg::OP_SW: w = {op, rd, 4'd15, rt};  // Based on r15
      proc_pkg::OP_LLB, proc_pkg::OP_LHB: begin
        t = take_bits(8);
        w = {op, rd, t[7:0]};
      end
      proc_pkg::OP_PCS: w = {op, rd, 8'h00};
      proc_pkg::OP_B: begin
        t     = take_bits(2);
        limit = DUMP_START - (idx + 1);            // Forward, never past the dump
        if (int'(t) > limit) t = 16'(limit);
        w = {op, rs[2:0], 7'd0, t[1:0]};           // Random condition
      end
      default: w = {op, rd, rs, rt};               // ALU ops and the spare no-ops
    endcase
    return w;
  endfunction

  task automatic build_program();
    prog.delete();
    prog.push_back({proc_pkg::OP_LLB, 4'd15, 8'h00});  // r15 = 0x8000 data base
    prog.push_back({proc_pkg::OP_LHB, 4'd15, 8'h80});
    for (int i = 0; i < N_RAND; i++) begin
      prog.push_back(random_inst(prog.size()));
    end
    for (int r = 1; r < 15; r++) begin
      prog.push_back({proc_pkg::OP_SW, 4'(r), 4'd15, 4'(r - 8)});  // Register dump
    end
    prog.push_back({proc_pkg::OP_HLT, 12'h000});
    for (int i = 0; i < prog.size(); i++) begin
      mem_write(SIDE_REF, 16'(2 * i), prog[i]);
      mem_write(SIDE_DUT, 16'(2 * i), prog[i]);
    end
  endtask

  //////////////////////////////
  // ISA model
  //////////////////////////////
  function automatic logic cond_holds(input logic [2:0] cc, input logic z, input logic n,
                                      input logic v);
    logic ok;
    case (proc_pkg::cond_t'(cc))
      proc_pkg::CC_NE: ok = !z;
      proc_pkg::CC_EQ: ok = z;
      proc_pkg::CC_GT: ok = !z && !n;
      proc_pkg::CC_LT: ok = n;
      proc_pkg::CC_GE: ok = z || !n;
      proc_pkg::CC_LE: ok = z || n;
      proc_pkg::CC_OV: ok = v;
      default:         ok = 1'b1;
    endcase
    return ok;
  endfunction

  task automatic run_model();
    logic [15:0] r [16];
    logic [15:0] pc_m, ins, a, b, res, addr, nxt;
    logic [3:0]  rd, imm4;
    logic        fz, fn, fv, wr, setz, done;
    int          s;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    {fz, fn, fv} = 3'b000;
    pc_m   = 16'h0000;
    done   = 1'b0;
    n_inst = 0;
    while (!done) begin
      ev_kind.push_back(EV_FETCH);
      ev_addr.push_back(pc_m);
      ev_data.push_back(16'h0000);
      ins  = mem_read(SIDE_REF, pc_m);
      rd   = ins[11:8];
      imm4 = ins[3:0];
      a    = r[ins[7:4]];
      b    = r[imm4];
      nxt  = pc_m + 16'd2;
      addr = (a & 16'hFFFE) + 16'(2 * int'($signed(imm4)));  // rs word plus imm4 words
      res  = '0;
      wr   = 1'b0;
      setz = 1'b0;
      n_inst++;
      case (ins[15:12])
        proc_pkg::OP_ADD, proc_pkg::OP_SUB: begin
          s   = (ins[15:12] == proc_pkg::OP_ADD) ? int'($signed(a)) + int'($signed(b))
                                                 : int'($signed(a)) - int'($signed(b));
          fv  = (s > 32767) || (s < -32768);
          res = (s > 32767) ? 16'h7FFF : ((s < -32768) ? 16'h8000 : s[15:0]);
          fn  = res[15];
          {wr, setz} = 2'b11;
        end
        proc_pkg::OP_XOR: {res, wr, setz} = {a ^ b, 2'b11};
        proc_pkg::OP_SLL: {res, wr, setz} = {a << imm4, 2'b11};
        proc_pkg::OP_SRA: begin
          res = $signed(a) >>> imm4;
          {wr, setz} = 2'b11;
        end
        proc_pkg::OP_ROR: begin
          res = a;
          for (int k = 0; k < int'(imm4); k++) begin
            res = {res[0], res[15:1]};  // One place right
          end
          {wr, setz} = 2'b11;
        end
        proc_pkg::OP_LLB: {res, wr} = {r[rd][15:8], ins[7:0], 1'b1};
        proc_pkg::OP_LHB: {res, wr} = {ins[7:0], r[rd][7:0], 1'b1};
        proc_pkg::OP_LW: begin
          ev_kind.push_back(EV_LOAD);
          ev_addr.push_back(addr);
          ev_data.push_back(16'h0000);
          {res, wr} = {mem_read(SIDE_REF, addr), 1'b1};
        end
        proc_pkg::OP_SW: begin
          ev_kind.push_back(EV_STORE);
          ev_addr.push_back(addr);
          ev_data.push_back(r[rd]);
          mem_write(SIDE_REF, addr, r[rd]);
        end
        proc_pkg::OP_B: begin
          if (cond_holds(ins[11:9], fz, fn, fv)) nxt = nxt + 16'(2 * int'($signed(ins[8:0])));
        end
        proc_pkg::OP_PCS: {res, wr} = {nxt, 1'b1};
        proc_pkg::OP_HLT: done = 1'b1;
        default: ;                                     // Spare opcodes do nothing
      endcase
      if (setz) fz = (res == 16'h0000);
      if (wr && (rd != 4'd0)) r[rd] = res;
      if (done) begin
        hlt_pc = pc_m;
      end else begin
        pc_m = nxt;
      end
      if (n_inst > 1000) abort_run("ISA model did not reach HLT");
    end
  endtask

  //////////////////////////////
  // Memory responder
  //////////////////////////////
  initial begin : responder
    logic [15:0] rd_addr, exp_addr, exp_data;
    int          wait_cnt, kind, n_req;
    bit          pend;
    mem_data_valid = 1'b0;
    mem_data_in    = 16'h0000;
    pend     = 1'b0;
    wait_cnt = 0;
    n_req    = 0;
    forever begin
      @(negedge clk);
      mem_data_valid = 1'b0;
      if (pend) begin
        check_val("read address hold", rd_addr, mem_addr);
        if (wait_cnt == 1) begin
          mem_data_valid = 1'b1;                       // One-cycle return
          mem_data_in    = mem_read(SIDE_DUT, rd_addr);
          pend           = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      if (rst_n && mem_en) begin
        if (pend) abort_run("Memory request issued while a read is outstanding");
        if (ev_kind.size() == 0) abort_run("Memory request after the last expected access");
        kind     = ev_kind.pop_front();
        exp_addr = ev_addr.pop_front();
        exp_data = ev_data.pop_front();
        n_req++;
        if (mem_wr) begin
          if (kind != EV_STORE) abort_run("Write issued where the model expects a read");
          check_val($sformatf("request %0d store address", n_req), exp_addr, mem_addr);
          check_val($sformatf("request %0d store data", n_req), exp_data, mem_data_out);
          mem_write(SIDE_DUT, mem_addr, mem_data_out);
        end else begin
          if (kind == EV_STORE) abort_run("Read issued where the model expects a write");
          check_val($sformatf("request %0d %s address", n_req,
                              (kind == EV_LOAD) ? "load" : "fetch"), exp_addr, mem_addr);
          rd_addr  = exp_addr;
          wait_cnt = int'(take_bits(2)) + 1;           // 1 to 4 cycles
          pend     = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    wait (wd_cycles != 0);
    #(wd_cycles * 4);
    $display("Timeout after %0d cycles, sequencer in state %s", wd_cycles, seq_state.name());
    $display("Test FAILED");
    $fatal(1);
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : main
    rst_n = 1'b0;
    lfsr  = 16'd5;                                     // Seed
    build_program();
    run_model();
    wd_cycles = n_inst * 12 + 40;                      // Plus reset and the quiet window
    $display("Program of %0d words runs %0d instructions", prog.size(), n_inst);
    repeat (2) @(negedge clk);
    check_val("mem_en after reset", 16'h0000, {15'd0, mem_en});
    check_val("mem_wr after reset", 16'h0000, {15'd0, mem_wr});
    check_val("hlt after reset", 16'h0000, {15'd0, hlt});
    check_val("pc after reset", 16'h0000, pc);
    rst_n = 1'b1;
    while (!hlt) @(negedge clk);
    check_val("pc at halt", hlt_pc, pc);
    if (ev_kind.size() != 0) abort_run("Core halted before all expected memory accesses");
    repeat (20) begin
      @(negedge clk);
      check_val("mem_en after halt", 16'h0000, {15'd0, mem_en});
      check_val("hlt held", 16'h0001, {15'd0, hlt});
    end
    $display("Test OK");
    $finish;
  end

endmodule

// ==== flist.f ====
proc_pkg.sv
fetch_unit.sv
reg_file.sv
alu.sv
core_seq.sv
mem_port.sv
proc_top.sv
tb_proc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the processor testbench with Verilator
verilator --binary --timing -f flist.f --top-module tb_proc -o tb_proc \
  && ./obj_dir/tb_proc \
  || exit 1
